// ==== hw/isa_pkg.sv ====
package isa_pkg;

	// One instruction word and one architectural register index
	typedef logic [31:0] instr_t;
	typedef logic [4:0] register_t;

	// Major opcodes, bits [6:0]
	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	// Full encodings of the system instructions that stop fetch
	localparam instr_t INSTR_ECALL = 32'h00000073;
	localparam instr_t INSTR_WFI   = 32'h10500073;
	localparam instr_t INSTR_MRET  = 32'h30200073;

	// What fetch does after issuing an instruction
	typedef enum logic [1:0] {
		CLASS_SEQUENTIAL,
		CLASS_REDIRECT,
		CLASS_WAIT_IRQ
	} instr_class_t;

endpackage

// ==== hw/fetch_pkg.sv ====
package fetch_pkg;

	// Byte address and debug counter widths
	typedef logic [31:0] pc_t;
	typedef logic [31:0] count_t;

	localparam pc_t RESET_VECTOR = 32'h00000000;

	// Direct-mapped cache, one word per line
	localparam int ICACHE_INDEX_BITS = 4;
	localparam int ICACHE_LINES = 1 << ICACHE_INDEX_BITS;
	localparam int ICACHE_TAG_BITS = 32 - ICACHE_INDEX_BITS - 2;

	typedef enum logic [1:0] {
		WAIT_ICACHE,
		WAIT_JUMP,
		WAIT_IRQ
	} fetch_state_t;

endpackage

// ==== hw/icache_if.sv ====
`timescale 1ns/10ps

interface icache_if
	import isa_pkg::*, fetch_pkg::*;
();

	// Lookup address and hold request from the fetch side
	pc_t pc;
	logic stall;

	// Word for the current pc, valid while ready is high
	instr_t rdata;
	logic ready;

	modport fetch (
		output pc,
		output stall,
		input rdata,
		input ready
	);

	modport cache (
		input pc,
		input stall,
		output rdata,
		output ready
	);

endinterface

// ==== hw/instr_predecode.sv ====
`timescale 1ns/10ps

module instr_predecode
	import isa_pkg::*;
(
	input instr_t i_instruction,
	output instr_class_t o_class,
	output register_t o_rs1,
	output register_t o_rs2,
	output register_t o_rd
);

	logic [6:0] opcode;
	logic have_rs1;
	logic have_rs2;
	logic have_rd;

	assign opcode = i_instruction[6:0];

	// Which register fields the format carries
	always_comb begin
		have_rs1 = 1'b0;
		have_rs2 = 1'b0;
		have_rd = 1'b0;
		case (opcode)
			OPC_LUI, OPC_AUIPC, OPC_JAL: begin
				have_rd = 1'b1;
			end
			OPC_JALR, OPC_LOAD, OPC_OP_IMM, OPC_SYSTEM: begin
				have_rs1 = 1'b1;
				have_rd = 1'b1;
			end
			OPC_BRANCH, OPC_STORE: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
			end
			OPC_OP: begin
				have_rs1 = 1'b1;
				have_rs2 = 1'b1;
				have_rd = 1'b1;
			end
			default: begin
				have_rd = 1'b0;
			end
		endcase
	end

	// Control transfers wait for the jump target, ecall and wfi for an interrupt
	always_comb begin
		if (opcode == OPC_JAL || opcode == OPC_JALR || opcode == OPC_BRANCH ||
				i_instruction == INSTR_MRET) begin
			o_class = CLASS_REDIRECT;
		end else if (i_instruction == INSTR_ECALL || i_instruction == INSTR_WFI) begin
			o_class = CLASS_WAIT_IRQ;
		end else begin
			o_class = CLASS_SEQUENTIAL;
		end
	end

	assign o_rs1 = have_rs1 ? i_instruction[19:15] : '0;
	assign o_rs2 = have_rs2 ? i_instruction[24:20] : '0;
	assign o_rd = have_rd ? i_instruction[11:7] : '0;

endmodule

// ==== hw/icache.sv ====
`timescale 1ns/10ps

module icache
	import isa_pkg::*, fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	icache_if.cache fetch,
	output logic o_bus_request,
	output pc_t o_bus_address,
	input logic i_bus_ready,
	input instr_t i_bus_rdata,
	output count_t o_hit,
	output count_t o_miss
);

	typedef logic [ICACHE_INDEX_BITS-1:0] index_t;
	typedef logic [ICACHE_TAG_BITS-1:0] tag_t;
	typedef enum logic {
		LOOKUP,
		REFILL
	} cache_state_t;

	cache_state_t state;

	logic [ICACHE_LINES-1:0] line_valid;
	tag_t line_tag [ICACHE_LINES];
	instr_t line_data [ICACHE_LINES];

	index_t lookup_index;
	tag_t lookup_tag;
	logic lookup_hit;
	index_t fill_index;
	logic start_refill;
	logic fill_done;

	// Registered lookup result
	pc_t word_pc;
	instr_t word_data;
	logic word_valid;

	// Set from line write until that word is taken, so it is not counted as a hit
	logic fresh_fill;

	assign lookup_index = fetch.pc[ICACHE_INDEX_BITS+1:2];
	assign lookup_tag = fetch.pc[31:ICACHE_INDEX_BITS+2];
	assign lookup_hit = line_valid[lookup_index] && line_tag[lookup_index] == lookup_tag;
	assign fill_index = o_bus_address[ICACHE_INDEX_BITS+1:2];

	assign start_refill = state == LOOKUP && !fetch.stall && !lookup_hit;
	assign fill_done = state == REFILL && i_bus_ready;

	// A stale word for an old pc is never shown
	assign fetch.rdata = word_data;
	assign fetch.ready = word_valid && word_pc == fetch.pc && !fetch.stall;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= LOOKUP;
			line_valid <= '0;
			o_bus_request <= 1'b0;
			word_valid <= 1'b0;
			fresh_fill <= 1'b0;
			o_hit <= '0;
			o_miss <= '0;
		end else begin
			if (fetch.ready) begin
				fresh_fill <= 1'b0;
				if (!fresh_fill)
					o_hit <= o_hit + 32'd1;
			end

			case (state)
				LOOKUP: begin
					word_valid <= lookup_hit && !fetch.stall;
					if (start_refill) begin
						state <= REFILL;
						o_bus_request <= 1'b1;
						o_miss <= o_miss + 32'd1;
					end
				end
				REFILL: begin
					word_valid <= 1'b0;
					if (fill_done) begin
						// Next lookup of the same pc hits the new line
						state <= LOOKUP;
						o_bus_request <= 1'b0;
						line_valid[fill_index] <= 1'b1;
						fresh_fill <= 1'b1;
					end
				end
				default: begin
					state <= LOOKUP;
				end
			endcase
		end
	end

	always_ff @(posedge i_clock) begin
		word_pc <= fetch.pc;
		word_data <= line_data[lookup_index];
		if (start_refill)
			o_bus_address <= {fetch.pc[31:2], 2'b00};
		if (fill_done) begin
			line_tag[fill_index] <= o_bus_address[31:ICACHE_INDEX_BITS+2];
			line_data[fill_index] <= i_bus_rdata;
		end
	end

endmodule

// ==== hw/fetch_unit.sv ====
`timescale 1ns/10ps

module fetch_unit
	import isa_pkg::*, fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	icache_if.fetch cache,
	input instr_class_t i_class,
	input register_t i_rs1,
	input register_t i_rs2,
	input register_t i_rd,
	input logic i_jump,
	input pc_t i_jump_pc,
	input logic i_irq_pending,
	input pc_t i_irq_pc,
	output logic o_irq_dispatched,
	output pc_t o_irq_epc,
	input logic i_busy,
	output logic o_strobe,
	output instr_t o_instruction,
	output pc_t o_pc,
	output register_t o_rs1,
	output register_t o_rs2,
	output register_t o_rd
);

	fetch_state_t state;
	pc_t pc;
	logic last_pending;

	logic irq_edge;
	logic consume;
	logic dispatch;
	logic emit;

	assign irq_edge = i_irq_pending && !last_pending;
	assign consume = state == WAIT_ICACHE && cache.ready;

	// Interrupt is taken on a consumed word or while parked on ecall/wfi
	assign dispatch = irq_edge && (consume || state == WAIT_IRQ);
	assign emit = consume && !irq_edge;

	assign cache.pc = pc;
	assign cache.stall = i_busy || state != WAIT_ICACHE;

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= WAIT_ICACHE;
			pc <= RESET_VECTOR;
			last_pending <= 1'b0;
			o_irq_dispatched <= 1'b0;
			o_strobe <= 1'b0;
		end else begin
			o_irq_dispatched <= 1'b0;
			case (state)
				WAIT_ICACHE: begin
					if (cache.ready) begin
						last_pending <= i_irq_pending;
						if (irq_edge) begin
							// Word is dropped and refetched after the handler returns
							o_irq_dispatched <= 1'b1;
							pc <= i_irq_pc;
						end else begin
							o_strobe <= ~o_strobe;
							pc <= pc + 32'd4;
							if (i_class == CLASS_REDIRECT)
								state <= WAIT_JUMP;
							else if (i_class == CLASS_WAIT_IRQ)
								state <= WAIT_IRQ;
						end
					end
				end
				WAIT_JUMP: begin
					if (i_jump) begin
						pc <= i_jump_pc;
						state <= WAIT_ICACHE;
					end
				end
				WAIT_IRQ: begin
					last_pending <= i_irq_pending;
					if (irq_edge) begin
						o_irq_dispatched <= 1'b1;
						pc <= i_irq_pc;
						state <= WAIT_ICACHE;
					end
				end
				default: begin
					state <= WAIT_ICACHE;
				end
			endcase
		end
	end

	// Output record, held until the next issued word
	always_ff @(posedge i_clock) begin
		if (emit) begin
			o_instruction <= cache.rdata;
			o_pc <= pc;
			o_rs1 <= i_rs1;
			o_rs2 <= i_rs2;
			o_rd <= i_rd;
		end
		// In WAIT_IRQ pc already points past the ecall or wfi
		if (dispatch)
			o_irq_epc <= pc;
	end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/10ps

module fetch_top
	import isa_pkg::*, fetch_pkg::*;
(
	input logic i_clock,
	input logic i_reset,
	input logic i_jump,
	input pc_t i_jump_pc,
	input logic i_irq_pending,
	input pc_t i_irq_pc,
	output logic o_irq_dispatched,
	output pc_t o_irq_epc,
	output logic o_bus_request,
	output pc_t o_bus_address,
	input logic i_bus_ready,
	input instr_t i_bus_rdata,
	input logic i_busy,
	output logic o_fetch_strobe,
	output instr_t o_fetch_instruction,
	output pc_t o_fetch_pc,
	output register_t o_fetch_rs1,
	output register_t o_fetch_rs2,
	output register_t o_fetch_rd,
	output count_t o_icache_hit,
	output count_t o_icache_miss
);

	icache_if fetch_if ();

	// Predecode of the word the cache presents
	instr_class_t pre_class;
	register_t pre_rs1;
	register_t pre_rs2;
	register_t pre_rd;

	instr_predecode u_instr_predecode (
		.i_instruction(fetch_if.rdata),
		.o_class(pre_class),
		.o_rs1(pre_rs1),
		.o_rs2(pre_rs2),
		.o_rd(pre_rd)
	);

	fetch_unit u_fetch_unit (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.cache(fetch_if.fetch),
		.i_class(pre_class),
		.i_rs1(pre_rs1),
		.i_rs2(pre_rs2),
		.i_rd(pre_rd),
		.i_jump(i_jump),
		.i_jump_pc(i_jump_pc),
		.i_irq_pending(i_irq_pending),
		.i_irq_pc(i_irq_pc),
		.o_irq_dispatched(o_irq_dispatched),
		.o_irq_epc(o_irq_epc),
		.i_busy(i_busy),
		.o_strobe(o_fetch_strobe),
		.o_instruction(o_fetch_instruction),
		.o_pc(o_fetch_pc),
		.o_rs1(o_fetch_rs1),
		.o_rs2(o_fetch_rs2),
		.o_rd(o_fetch_rd)
	);

	icache u_icache (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.fetch(fetch_if.cache),
		.o_bus_request(o_bus_request),
		.o_bus_address(o_bus_address),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata),
		.o_hit(o_icache_hit),
		.o_miss(o_icache_miss)
	);

endmodule

// ==== sim/tb_fetch_top.sv ====
`timescale 1ns/10ps

module tb_fetch_top
	import isa_pkg::*, fetch_pkg::*;
();

	// One row of the stimulus table
	typedef struct packed {
		logic [7:0] quiet;
		logic busy;
		logic jump;
		pc_t target;
		logic pending;
		pc_t vector;
		logic dispatch;
		pc_t pc;
		register_t rs1;
		register_t rs2;
		register_t rd;
	} step_t;

	logic i_clock;
	logic i_reset;
	logic i_jump;
	pc_t i_jump_pc;
	logic i_irq_pending;
	pc_t i_irq_pc;
	logic o_irq_dispatched;
	pc_t o_irq_epc;
	logic o_bus_request;
	pc_t o_bus_address;
	logic i_bus_ready;
	instr_t i_bus_rdata;
	logic i_busy;
	logic o_fetch_strobe;
	instr_t o_fetch_instruction;
	pc_t o_fetch_pc;
	register_t o_fetch_rs1;
	register_t o_fetch_rs2;
	register_t o_fetch_rd;
	count_t o_icache_hit;
	count_t o_icache_miss;

	instr_t mem [64];
	bit seen [64];
	step_t steps [$];
	int idx;
	int mismatches;
	int failures;
	int exp_hits;
	int exp_misses;
	logic last_strobe;
	pc_t last_pc;
	bit parked;
	bit abort;
	bit got_record;
	bit got_dispatch;

	fetch_top u_fetch_top (.*);

	initial begin
		i_clock = 1'b0;
		forever #5 i_clock = ~i_clock;
	end

	// Word memory that answers each bus request after 0 to 3 idle cycles
	initial begin : memory_model
		int first_draw;
		int wait_left;
		bit serving;
		first_draw = $urandom(32'hd0ddf7dd);
		serving = 1'b0;
		wait_left = 0;
		forever begin
			@(posedge i_clock);
			#1;
			i_bus_ready = 1'b0;
			if (o_bus_request === 1'b1) begin
				if (!serving) begin
					serving = 1'b1;
					wait_left = $urandom_range(3, 0);
				end
				if (wait_left == 0) begin
					i_bus_ready = 1'b1;
					i_bus_rdata = mem[o_bus_address[7:2]];
					serving = 1'b0;
				end else begin
					wait_left--;
				end
			end
		end
	end

	task automatic check_pc(input string what, input pc_t got, input pc_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
			mismatches++;
		end
	endtask

	task automatic check_instr(input string what, input instr_t got, input instr_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %h, expected %h", $time, what, got, want);
			mismatches++;
		end
	endtask

	task automatic check_reg(input string what, input register_t got, input register_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is x%0d, expected x%0d", $time, what, got, want);
			mismatches++;
		end
	endtask

	task automatic check_count(input string what, input count_t got, input count_t want);
		if (got !== want) begin
			$display("MISMATCH at %0t: %s is %0d, expected %0d", $time, what, got, want);
			mismatches++;
		end
	endtask

	task automatic add_step(input int quiet, input bit busy, input bit jump, input pc_t target,
			input bit pending, input pc_t vector, input bit dispatch, input pc_t pc,
			input register_t rs1, input register_t rs2, input register_t rd);
		steps.push_back({quiet[7:0], busy, jump, target, pending, vector, dispatch, pc,
			rs1, rs2, rd});
	endtask

	// A word seen before hits and a new one costs one line fill
	task automatic note_consumed(input pc_t pc);
		if (seen[pc[7:2]]) begin
			exp_hits++;
		end else begin
			seen[pc[7:2]] = 1'b1;
			exp_misses++;
		end
	endtask

	task automatic await_result();
		int cycles;
		cycles = 0;
		got_record = 1'b0;
		got_dispatch = 1'b0;
		while (!got_record && !got_dispatch && cycles < 200) begin
			@(posedge i_clock);
			#1;
			// Jump is a single-cycle pulse
			i_jump = 1'b0;
			got_record = o_fetch_strobe !== last_strobe;
			got_dispatch = o_irq_dispatched === 1'b1;
			cycles++;
		end
	endtask

	task automatic run_step(input step_t s);
		int c;
		i_busy = s.busy;
		// Nothing may come out while held by busy or by a wait state
		for (c = 0; c < s.quiet; c++) begin
			@(posedge i_clock);
			#1;
			if (o_fetch_strobe !== last_strobe || o_irq_dispatched !== 1'b0) begin
				$display("Fetch output changed at %0t while fetch should be held", $time);
				failures++;
			end
			check_pc("held pc", o_fetch_pc, last_pc);
		end
		i_busy = 1'b0;
		i_jump = s.jump;
		i_jump_pc = s.target;
		i_irq_pending = s.pending;
		i_irq_pc = s.vector;
		await_result();
		if (!got_record && !got_dispatch) begin
			$display("Timeout at %0t: no fetch record and no dispatch in 200 cycles", $time);
			failures++;
			abort = 1'b1;
		end else if (got_dispatch != s.dispatch) begin
			if (got_dispatch)
				$display("Unexpected interrupt dispatch at %0t", $time);
			else
				$display("Fetch record at %0t where a dispatch was expected", $time);
			failures++;
			last_strobe = o_fetch_strobe;
		end else if (got_dispatch) begin
			check_pc("epc", o_irq_epc, s.pc);
			// Parked on ecall or wfi so no word was taken
			if (!parked)
				note_consumed(s.pc);
			parked = 1'b0;
		end else begin
			last_strobe = o_fetch_strobe;
			last_pc = o_fetch_pc;
			check_pc("pc", o_fetch_pc, s.pc);
			check_instr("instruction", o_fetch_instruction, mem[s.pc[7:2]]);
			check_reg("rs1", o_fetch_rs1, s.rs1);
			check_reg("rs2", o_fetch_rs2, s.rs2);
			check_reg("rd", o_fetch_rd, s.rd);
			note_consumed(s.pc);
			parked = mem[s.pc[7:2]] == INSTR_ECALL || mem[s.pc[7:2]] == INSTR_WFI;
		end
	endtask

	initial begin
		i_reset = 1'b1;
		i_jump = 1'b0;
		i_jump_pc = '0;
		i_irq_pending = 1'b0;
		i_irq_pc = '0;
		i_bus_ready = 1'b0;
		i_bus_rdata = '0;
		i_busy = 1'b0;
		mismatches = 0;
		failures = 0;
		exp_hits = 0;
		exp_misses = 0;
		for (idx = 0; idx < 64; idx++) begin
			// Filler addi to x0 with the word index as immediate
			mem[idx] = 32'h00000013 | (idx << 20);
			seen[idx] = 1'b0;
		end
		mem[0] = 32'h00500093;
		mem[1] = 32'h00112223;
		mem[2] = 32'h002081b3;
		mem[3] = 32'h00208263;
		mem[4] = 32'h123452b7;
		mem[5] = 32'h00000073;
		mem[8] = 32'h00300413;
		mem[9] = 32'h00442483;
		mem[10] = 32'h00946533;
		mem[11] = 32'h10500073;
		mem[16] = 32'h00130313;
		mem[17] = 32'h00138393;
		mem[18] = 32'hff9ff06f;
		mem[24] = 32'h30200073;

		// quiet, busy, jump, target, pending, vector, dispatch, pc or epc, rs1, rs2, rd
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h00, 0, 0, 1);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h04, 2, 1, 0);
		add_step(8, 1, 0, 32'h00, 0, 32'h00, 0, 32'h08, 1, 2, 3);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h0c, 1, 2, 0);
		add_step(8, 0, 1, 32'h10, 0, 32'h00, 0, 32'h10, 0, 0, 5);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h14, 0, 0, 0);
		add_step(8, 0, 0, 32'h00, 1, 32'h40, 1, 32'h18, 0, 0, 0);
		add_step(0, 0, 0, 32'h00, 1, 32'h40, 0, 32'h40, 6, 0, 6);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h44, 7, 0, 7);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h48, 0, 0, 0);
		add_step(8, 0, 1, 32'h40, 0, 32'h00, 0, 32'h40, 6, 0, 6);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h44, 7, 0, 7);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h48, 0, 0, 0);
		add_step(8, 0, 1, 32'h20, 0, 32'h00, 0, 32'h20, 0, 0, 8);
		add_step(0, 0, 0, 32'h00, 1, 32'h60, 1, 32'h24, 0, 0, 0);
		add_step(0, 0, 0, 32'h00, 1, 32'h60, 0, 32'h60, 0, 0, 0);
		add_step(8, 0, 1, 32'h24, 0, 32'h00, 0, 32'h24, 8, 0, 9);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h28, 8, 9, 10);
		add_step(0, 0, 0, 32'h00, 0, 32'h00, 0, 32'h2c, 0, 0, 0);

		repeat (3) @(posedge i_clock);
		#1;
		i_reset = 1'b0;
		if (o_fetch_strobe !== 1'b0 || o_bus_request !== 1'b0 || o_irq_dispatched !== 1'b0) begin
			$display("Outputs not inactive after reset at %0t", $time);
			failures++;
		end
		last_strobe = 1'b0;
		last_pc = '0;
		parked = 1'b0;
		abort = 1'b0;
		for (idx = 0; idx < steps.size() && !abort; idx++)
			run_step(steps[idx]);
		if (!abort) begin
			check_count("hit counter", o_icache_hit, exp_hits);
			check_count("miss counter", o_icache_miss, exp_misses);
		end

		$display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

// ==== files.f ====
hw/isa_pkg.sv
hw/fetch_pkg.sv
hw/icache_if.sv
hw/instr_predecode.sv
hw/icache.sv
hw/fetch_unit.sv
hw/fetch_top.sv
sim/tb_fetch_top.sv
